//--- hdl/bankCopier.sv
/*
 * Copy and serve stage
 * Moves a held front set into the back banks, then serves consumer reads
 * with K until computeFinished
 */

`timescale 1ns/10ps

module bankCopier import matrixBufferPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  stageFull,
    input  kT     setK,
    input  logic  setNewA,
    input  elemT  frontAData,
    input  elemT  frontBData,
    output aAddrT frontAAddr,
    output bAddrT frontBAddr,
    output logic  copyTaken,
    input  aAddrT aReadAddr,
    input  bAddrT bReadAddr,
    input  logic  computeFinished,
    output logic  matricesLoaded,
    output kT     k,
    output elemT  aData,
    output elemT  bData
);

    copyStateT state;

    // Read counter, sized for the larger B bank and shared by both copies
    bAddrT rdCount;
    bAddrT wrAddr;          // rdCount delayed one cycle, matches RAM read latency
    logic  wrEnA;
    logic  wrEnB;

    logic  aDone;
    logic  bDone;
    aAddrT backAAddr;
    bAddrT backBAddr;

    // Counter one past the last element means only the final write is left
    assign aDone = (rdCount == bAddrT'(rowsA * setK));
    assign bDone = (rdCount == bAddrT'(colsB * setK));

    assign frontAAddr = aAddrT'(rdCount);
    assign frontBAddr = rdCount;

    // Last B write is the last copy cycle, front banks are free after it
    assign copyTaken = (state == copyB) && bDone;

    assign matricesLoaded = (state == serve);

    // Consumer owns the back banks while serving
    assign backAAddr = matricesLoaded ? aReadAddr : aAddrT'(wrAddr);
    assign backBAddr = matricesLoaded ? bReadAddr : wrAddr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            rdCount <= '0;
            wrEnA   <= 1'b0;
            wrEnB   <= 1'b0;
            k       <= '0;
        end else begin
            // Write enables are single-cycle unless reissued below
            wrEnA <= 1'b0;
            wrEnB <= 1'b0;
            unique case (state)
                idle: begin
                    if (stageFull) begin
                        // Skip A when the set carries B only
                        state <= setNewA ? copyA : copyB;
                    end
                end
                copyA: begin
                    if (aDone) begin
                        rdCount <= '0;
                        state   <= copyB;
                    end else begin
                        wrEnA   <= 1'b1;                // Write lands next cycle
                        rdCount <= rdCount + 1'b1;
                    end
                end
                copyB: begin
                    if (bDone) begin
                        rdCount <= '0;
                        k       <= setK;
                        state   <= serve;
                    end else begin
                        wrEnB   <= 1'b1;
                        rdCount <= rdCount + 1'b1;
                    end
                end
                serve: begin
                    if (computeFinished) begin
                        state <= idle;                  // matricesLoaded drops next cycle
                    end
                end
            endcase
        end
    end

    // Write address pipeline, gated by wrEnA/wrEnB
    always_ff @(posedge clk) begin
        wrAddr <= rdCount;
    end

    // Back A is only written in copyA, so B-only sets keep the old A
    matrixMemory #(
        .width (elemWidth),
        .depth (aDepth)
    ) backA (
        .clk    (clk),
        .wrEn   (wrEnA),
        .addr   (backAAddr),
        .wrData (frontAData),
        .rdData (aData)
    );

    matrixMemory #(
        .width (elemWidth),
        .depth (bDepth)
    ) backB (
        .clk    (clk),
        .wrEn   (wrEnB),
        .addr   (backBAddr),
        .wrData (frontBData),
        .rdData (bData)
    );

endmodule

//--- hdl/matrixBufferPkg.sv
/*
 * Matrix input buffer shared definitions
 * Dimensions, derived widths, element/address/K types and FSM encodings
 */

package matrixBufferPkg;

    // Matrix dimensions
    localparam int elemWidth = 12;              // Bits per signed element
    localparam int rowsA     = 7;               // M, rows of A
    localparam int colsB     = 9;               // N, columns of B
    localparam int maxK      = 8;               // Largest shared dimension

    // Derived widths
    localparam int kWidth     = $clog2(maxK + 1);       // Holds 0..maxK
    localparam int aAddrWidth = $clog2(rowsA * maxK);
    localparam int bAddrWidth = $clog2(maxK * colsB);

    // Bank depths, full power of two per address width
    localparam int aDepth = 2 ** aAddrWidth;
    localparam int bDepth = 2 ** bAddrWidth;

    typedef logic signed [elemWidth-1:0] elemT;
    typedef logic [kWidth-1:0]           kT;
    typedef logic [aAddrWidth-1:0]       aAddrT;
    typedef logic [bAddrWidth-1:0]       bAddrT;

    // Stream user field, newA in bit 0 and K above it
    typedef logic [kWidth:0] tuserT;

    // Ingest side FSM
    typedef enum logic [1:0] {
        takeFirst,      // Waiting for first beat, samples tuser
        storeA,         // Filling front A
        storeB,         // Filling front B
        holdFull        // Set complete, stream stalled
    } ingestStateT;

    // Copy and serve FSM
    typedef enum logic [1:0] {
        idle,           // Back banks free, waiting for a full front set
        copyA,
        copyB,
        serve           // matricesLoaded high
    } copyStateT;

endpackage

//--- hdl/matrixInputBuffer.sv
/*
 * Double-buffered matrix input buffer
 * Stream ingest into front banks, copy into back banks, serve the consumer
 */

`timescale 1ns/10ps

module matrixInputBuffer import matrixBufferPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  elemT  tdata,
    input  logic  tvalid,
    input  tuserT tuser,
    output logic  tready,
    output logic  matricesLoaded,
    input  logic  computeFinished,
    output kT     k,
    input  aAddrT aReadAddr,
    output elemT  aData,
    input  bAddrT bReadAddr,
    output elemT  bData
);

    // Handoff between the two stages
    logic  stageFull;
    logic  copyTaken;
    kT     setK;
    logic  setNewA;
    aAddrT frontAAddr;
    bAddrT frontBAddr;
    elemT  frontAData;
    elemT  frontBData;

    streamIngest ingest (
        .clk        (clk),
        .reset      (reset),
        .tdata      (tdata),
        .tvalid     (tvalid),
        .tuser      (tuser),
        .tready     (tready),
        .frontAAddr (frontAAddr),
        .frontBAddr (frontBAddr),
        .copyTaken  (copyTaken),
        .stageFull  (stageFull),
        .setK       (setK),
        .setNewA    (setNewA),
        .frontAData (frontAData),
        .frontBData (frontBData)
    );

    bankCopier copier (
        .clk             (clk),
        .reset           (reset),
        .stageFull       (stageFull),
        .setK            (setK),
        .setNewA         (setNewA),
        .frontAData      (frontAData),
        .frontBData      (frontBData),
        .frontAAddr      (frontAAddr),
        .frontBAddr      (frontBAddr),
        .copyTaken       (copyTaken),
        .aReadAddr       (aReadAddr),
        .bReadAddr       (bReadAddr),
        .computeFinished (computeFinished),
        .matricesLoaded  (matricesLoaded),
        .k               (k),
        .aData           (aData),
        .bData           (bData)
    );

endmodule

//--- hdl/matrixMemory.sv
/*
 * Single-port synchronous RAM
 * Synchronous write, registered read, shared by all four matrix banks
 */

`timescale 1ns/10ps

module matrixMemory #(
    parameter int width = 12,
    parameter int depth = 64
) (
    input  logic                     clk,
    input  logic                     wrEn,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [width-1:0]         wrData,
    output logic [width-1:0]         rdData
);

    logic [width-1:0] mem [depth];      // Storage array

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wrData;
        end
        rdData <= mem[addr];            // Old contents on a write cycle
    end

endmodule

//--- hdl/streamIngest.sv
/*
 * Stream ingest stage
 * Takes A then B (or B only) from the valid/ready stream into the front banks,
 * then holds the set and lends the bank read ports to the copy stage
 */

`timescale 1ns/10ps

module streamIngest import matrixBufferPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  elemT  tdata,
    input  logic  tvalid,
    input  tuserT tuser,
    output logic  tready,
    input  aAddrT frontAAddr,       // Copier read address, used in holdFull
    input  bAddrT frontBAddr,
    input  logic  copyTaken,
    output logic  stageFull,
    output kT     setK,
    output logic  setNewA,
    output elemT  frontAData,
    output elemT  frontBData
);

    ingestStateT state;

    aAddrT aCount;                  // Next A write address
    bAddrT bCount;                  // Next B write address
    aAddrT aAddr;
    bAddrT bAddr;
    logic  aWrEn;
    logic  bWrEn;

    logic  firstNewA;               // tuser fields, only meaningful on first beat
    kT     firstK;
    logic  aLast;
    logic  bLast;

    assign firstNewA = tuser[0];
    assign firstK    = tuser[kWidth:1];

    // End of each matrix, uses the latched K
    assign aLast = (aCount == aAddrT'(rowsA * setK - 1));
    assign bLast = (bCount == bAddrT'(colsB * setK - 1));

    assign tready    = (state != holdFull);     // Stall while a set is held
    assign stageFull = (state == holdFull);

    // Write steering and bank address select
    always_comb begin
        aWrEn = 1'b0;
        bWrEn = 1'b0;
        aAddr = aCount;
        bAddr = bCount;
        unique case (state)
            takeFirst: begin
                // First beat goes to A or B depending on newA
                aWrEn = tvalid & firstNewA;
                bWrEn = tvalid & ~firstNewA;
            end
            storeA: aWrEn = tvalid;
            storeB: bWrEn = tvalid;
            holdFull: begin
                // Copier owns the read side now
                aAddr = frontAAddr;
                bAddr = frontBAddr;
            end
        endcase
    end

    // Control path
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= takeFirst;
            aCount <= '0;
            bCount <= '0;
        end else begin
            unique case (state)
                takeFirst: begin
                    if (tvalid) begin
                        if (firstNewA) begin
                            aCount <= aCount + 1'b1;
                            state  <= storeA;
                        end else begin
                            bCount <= bCount + 1'b1;    // B only, A kept downstream
                            state  <= storeB;
                        end
                    end
                end
                storeA: begin
                    if (tvalid) begin
                        if (aLast) begin
                            state <= storeB;            // bCount still zero here
                        end else begin
                            aCount <= aCount + 1'b1;
                        end
                    end
                end
                storeB: begin
                    if (tvalid) begin
                        if (bLast) begin
                            state <= holdFull;          // stageFull from next cycle
                        end else begin
                            bCount <= bCount + 1'b1;
                        end
                    end
                end
                holdFull: begin
                    // Front banks released once the copier is done
                    if (copyTaken) begin
                        aCount <= '0;
                        bCount <= '0;
                        state  <= takeFirst;
                    end
                end
            endcase
        end
    end

    // Set descriptor, sampled on the first beat only
    always_ff @(posedge clk) begin
        if (state == takeFirst && tvalid) begin
            setK    <= firstK;
            setNewA <= firstNewA;
        end
    end

    matrixMemory #(
        .width (elemWidth),
        .depth (aDepth)
    ) frontA (
        .clk    (clk),
        .wrEn   (aWrEn),
        .addr   (aAddr),
        .wrData (tdata),
        .rdData (frontAData)
    );

    matrixMemory #(
        .width (elemWidth),
        .depth (bDepth)
    ) frontB (
        .clk    (clk),
        .wrEn   (bWrEn),
        .addr   (bAddr),
        .wrData (tdata),
        .rdData (frontBData)
    );

endmodule

//--- test/matrixTbModel.svh
/*
 * Reference model for the matrix input buffer testbench
 * Staged and loaded A/B contents, expected values and the set sender
 */

`ifndef MATRIX_TB_MODEL_SVH
`define MATRIX_TB_MODEL_SVH

elemT modelA [rowsA*maxK];          // What the back banks should hold
elemT modelB [maxK*colsB];
elemT stageA [rowsA*maxK];          // Set still on its way through the front banks
elemT stageB [maxK*colsB];
bit   stageNewA;

// Expected element of the loaded set at one bank address
function automatic elemT expectedElem(input bit isA, input int addr);
    if (isA) begin
        return modelA[addr];
    end
    return modelB[addr];
endfunction

// Staged set becomes the loaded one, A survives a B-only set
task commitSet();
    for (int i = 0; i < maxK*colsB; i++) begin
        modelB[i] = stageB[i];
    end
    if (stageNewA) begin
        for (int i = 0; i < rowsA*maxK; i++) begin
            modelA[i] = stageA[i];
        end
    end
endtask

// Streams one set, A first when newA, optional idle cycles before each beat
task sendSet(input int kVal, input bit newA, input bit gaps);
    int aBeats;
    int total;
    int gap;
    aBeats    = newA ? rowsA * kVal : 0;
    total     = aBeats + colsB * kVal;
    stageNewA = newA;
    for (int i = 0; i < aBeats; i++) begin
        stageA[i] = elemT'($random(seed));
    end
    for (int i = 0; i < colsB * kVal; i++) begin
        stageB[i] = elemT'($random(seed));
    end
    @(posedge clk);
    for (int i = 0; i < total; i++) begin
        if (gaps) begin
            gap = $random(seed) & 3;        // 0..3 idle cycles
            repeat (gap) begin
                tvalid <= 1'b0;
                @(posedge clk);
            end
        end
        tvalid <= 1'b1;
        tdata  <= (i < aBeats) ? stageA[i] : stageB[i - aBeats];
        tuser  <= {kT'(kVal), newA};        // Only the first beat counts
        @(posedge clk);
        while (!tready) begin
            @(posedge clk);                 // Beat held until accepted
        end
    end
    tvalid <= 1'b0;
endtask

`endif

//--- test/matrixInputBufferTb.sv
/*
 * Testbench for the double-buffered matrix input buffer
 * Streams sets, reads back the served banks and checks against the model
 */

`timescale 1ns/10ps

module matrixInputBufferTb import matrixBufferPkg::*; ();

    // Beats of all sets: K=3 full, K=3 B only, K=maxK full, K=1 full
    localparam int totalBeats  = 3*(rowsA+colsB) + 3*colsB + maxK*(rowsA+colsB) + (rowsA+colsB);
    localparam int maxGap      = 4;                             // Cycles per beat with gaps
    localparam int copyCycles  = 4 * ((rowsA+colsB)*maxK + 4);
    localparam int checkCycles = 5 * 2 * colsB * maxK;          // Readback passes
    localparam int timeoutNs   = 2 * 20 * (totalBeats*maxGap + copyCycles + checkCycles);

    logic  clk = 1'b0;
    logic  reset;
    elemT  tdata;
    logic  tvalid;
    tuserT tuser;
    logic  tready;
    logic  matricesLoaded;
    logic  computeFinished;
    kT     k;
    aAddrT aReadAddr;
    elemT  aData;
    bAddrT bReadAddr;
    elemT  bData;

    integer seed = 17;
    int     errorCount = 0;
    int     testErrors = 0;
    int     testCount = 0;
    int     acceptedBeats = 0;
    int     beatsBefore;
    bit     holdWatch = 1'b0;     // tready must stay low while set
    string  checkName;
    int     checkK;
    event   startCheck;
    event   checkFinished;

    `include "matrixTbModel.svh"

    matrixInputBuffer DUT (
        .clk             (clk),
        .reset           (reset),
        .tdata           (tdata),
        .tvalid          (tvalid),
        .tuser           (tuser),
        .tready          (tready),
        .matricesLoaded  (matricesLoaded),
        .computeFinished (computeFinished),
        .k               (k),
        .aReadAddr       (aReadAddr),
        .aData           (aData),
        .bReadAddr       (bReadAddr),
        .bData           (bData)
    );

    always #10 clk = ~clk;          // 20 ns period

    always @(posedge clk) begin
        if (tvalid && tready) begin
            acceptedBeats++;        // Handshake seen on this edge
        end
    end

    always @(negedge clk) begin
        if (holdWatch) begin
            assert (!tready) else reportProblem("doubleBuffer", "tready high while a set is held");
        end
    end

    task reportMismatch(input string name, input string what, input int expected, input int actual);
        $display("** Error: %s %s expected %0d, actual %0d", name, what, expected, actual);
        errorCount++;
        testErrors++;
    endtask

    task reportProblem(input string name, input string what);
        $display("%s: %s", name, what);
        errorCount++;
        testErrors++;
    endtask

    task finishTest(input string name);
        $display("%-14s %s", name, (testErrors == 0) ? "ok" : "mismatches");
        testCount++;
        testErrors = 0;
    endtask

    task checkSet(input string name, input int kVal);
        checkName = name;
        checkK    = kVal;
        -> startCheck;
        @(checkFinished);
    endtask

    task waitLoaded();
        @(posedge clk);
        while (!matricesLoaded) begin
            @(posedge clk);
        end
    endtask

    // One-cycle computeFinished, matricesLoaded must drop right after it
    task pulseFinish(input string name);
        @(posedge clk);
        computeFinished <= 1'b1;
        @(negedge clk);
        assert (matricesLoaded) else reportProblem(name, "matricesLoaded low before computeFinished");
        @(posedge clk);
        computeFinished <= 1'b0;
        @(negedge clk);
        assert (!matricesLoaded) else reportProblem(name, "matricesLoaded still high after computeFinished");
    endtask

    // Readback: address on one edge, data compared in the following cycle
    initial begin : compareProc
        elemT expA;
        elemT expB;
        forever begin
            @(startCheck);
            for (int i = 0; i < colsB * checkK; i++) begin
                @(posedge clk);
                aReadAddr <= aAddrT'((i < rowsA * checkK) ? i : 0);
                bReadAddr <= bAddrT'(i);
                @(posedge clk);
                @(negedge clk);
                expA = expectedElem(1'b1, (i < rowsA * checkK) ? i : 0);
                expB = expectedElem(1'b0, i);
                assert (matricesLoaded) else reportProblem(checkName, "matricesLoaded low during readback");
                assert (aData == expA) else reportMismatch(checkName, $sformatf("A[%0d]", i), expA, aData);
                assert (bData == expB) else reportMismatch(checkName, $sformatf("B[%0d]", i), expB, bData);
            end
            assert (k == kT'(checkK)) else reportMismatch(checkName, "k", checkK, k);
            -> checkFinished;
        end
    end

    initial begin : watchdog
        #(timeoutNs);
        $display("Watchdog expired, the DUT did not finish the tests in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        reset           = 1'b1;
        tdata           = '0;
        tvalid          = 1'b0;
        tuser           = '0;
        computeFinished = 1'b0;
        aReadAddr       = '0;
        bReadAddr       = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (tready) else reportMismatch("afterReset", "tready", 1, tready);
        assert (!matricesLoaded) else reportMismatch("afterReset", "matricesLoaded", 0, matricesLoaded);
        assert (k == '0) else reportMismatch("afterReset", "k", 0, k);
        finishTest("afterReset");

        sendSet(3, 1'b1, 1'b0);
        waitLoaded();
        commitSet();
        checkSet("fullLoad", 3);
        pulseFinish("fullLoad");
        finishTest("fullLoad");

        sendSet(3, 1'b0, 1'b0);     // A must survive in the back bank
        waitLoaded();
        commitSet();
        checkSet("bOnlyLoad", 3);
        finishTest("bOnlyLoad");

        // Next set streams in while the B-only set is still served
        @(posedge clk);
        beatsBefore = acceptedBeats;
        fork
            begin
                sendSet(maxK, 1'b1, 1'b0);
                holdWatch = 1'b1;
                tvalid    <= 1'b1;      // Surplus beat stays offered against the held set
            end
            checkSet("doubleBuffer", 3);
        join
        pulseFinish("doubleBuffer");
        @(posedge clk);
        tvalid    <= 1'b0;
        holdWatch = 1'b0;
        @(negedge clk);
        assert (acceptedBeats - beatsBefore == (rowsA + colsB) * maxK) else
            reportMismatch("doubleBuffer", "beats", (rowsA + colsB) * maxK, acceptedBeats - beatsBefore);
        waitLoaded();
        commitSet();
        checkSet("doubleBuffer", maxK);
        pulseFinish("doubleBuffer");
        finishTest("doubleBuffer");

        sendSet(1, 1'b1, 1'b1);
        waitLoaded();
        commitSet();
        checkSet("randomGaps", 1);
        pulseFinish("randomGaps");
        finishTest("randomGaps");

        $display("%0d tests, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+test
hdl/matrixBufferPkg.sv
hdl/matrixMemory.sv
hdl/streamIngest.sv
hdl/bankCopier.sv
hdl/matrixInputBuffer.sv
test/matrixInputBufferTb.sv
